//--- Makefile
SIM      = verilator
VFLAGS   = --binary --timing --assert -Wno-fatal
TOP      = tb_cam_qspi_top
FILELIST = sim.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim.f
+incdir+testbench
src/capture_pkg.sv
src/qspi_pkg.sv
src/cam_word_packer.sv
src/frame_buffer.sv
src/qspi_stream_writer.sv
src/wb_ctrl_regs.sv
src/cam_qspi_top.sv
testbench/tb_cam_qspi_top.sv

//--- src/cam_qspi_top.sv
// Camera to quad-SPI SRAM capture top level
// Packs camera bytes into a ping-pong frame buffer, streams full banks
// to the serial SRAM and exposes a small host control port
`timescale 1ns/10ps

module cam_qspi_top #(
	parameter int BANK_WORDS      = 512,  // Words per buffer bank
	parameter int BURST_BYTES     = 512,  // Bytes per SRAM write burst
	parameter int QSPI_START_ADDR = 4     // SRAM address of first burst
) (
	input  logic                    WBs_CLK_i,
	input  logic                    WBs_RST_i,
	input  logic                    WBs_STATUS_CYC_i,
	input  logic                    WBs_STB_i,
	input  logic                    WBs_WE_i,
	input  capture_pkg::host_word_t WBs_DAT_i,
	output logic                    WBs_ACK_o,
	output capture_pkg::host_word_t WBs_STATUS_o,
	input  capture_pkg::cam_byte_t  cam_dat_i,
	input  logic                    href_i,
	input  logic                    vsync_i,
	output logic [3:0]              qspi_io_o,
	output logic                    qspi_ncs_o
);

	capture_pkg::pixel_word_u word;
	logic                     word_valid;
	capture_pkg::bank_addr_t  wr_addr;
	logic                     wr_bank;        // Bank the camera fills
	logic                     rd_en;
	logic                     rd_bank;
	capture_pkg::bank_addr_t  rd_addr;
	capture_pkg::pixel_word_u rd_data;
	logic                     stream_en;

	// --------------------------------------------------
	// Capture path
	// --------------------------------------------------
	cam_word_packer #(.BANK_WORDS(BANK_WORDS)) i_cam_word_packer (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.cam_dat_i    (cam_dat_i),
		.href_i       (href_i),
		.vsync_i      (vsync_i),
		.word_o       (word),
		.word_valid_o (word_valid),
		.wr_addr_o    (wr_addr),
		.wr_bank_o    (wr_bank)
	);

	frame_buffer #(.BANK_WORDS(BANK_WORDS)) i_frame_buffer (
		.WBs_CLK_i (WBs_CLK_i),
		.wr_en_i   (word_valid),
		.wr_bank_i (wr_bank),
		.wr_addr_i (wr_addr),
		.wr_data_i (word),
		.rd_en_i   (rd_en),
		.rd_bank_i (rd_bank),
		.rd_addr_i (rd_addr),
		.rd_data_o (rd_data)
	);

	// --------------------------------------------------
	// SRAM streaming and host port
	// --------------------------------------------------
	qspi_stream_writer #(
		.BANK_WORDS      (BANK_WORDS),
		.BURST_BYTES     (BURST_BYTES),
		.QSPI_START_ADDR (QSPI_START_ADDR)
	) i_qspi_stream_writer (
		.WBs_CLK_i   (WBs_CLK_i),
		.WBs_RST_i   (WBs_RST_i),
		.stream_en_i (stream_en),
		.cam_bank_i  (wr_bank),
		.rd_en_o     (rd_en),
		.rd_bank_o   (rd_bank),
		.rd_addr_o   (rd_addr),
		.rd_data_i   (rd_data),
		.qspi_io_o   (qspi_io_o),
		.qspi_ncs_o  (qspi_ncs_o)
	);

	wb_ctrl_regs i_wb_ctrl_regs (
		.WBs_CLK_i        (WBs_CLK_i),
		.WBs_RST_i        (WBs_RST_i),
		.WBs_STATUS_CYC_i (WBs_STATUS_CYC_i),
		.WBs_STB_i        (WBs_STB_i),
		.WBs_WE_i         (WBs_WE_i),
		.WBs_DAT_i        (WBs_DAT_i),
		.vsync_i          (vsync_i),
		.cam_bank_i       (wr_bank),
		.WBs_ACK_o        (WBs_ACK_o),
		.WBs_STATUS_o     (WBs_STATUS_o),
		.stream_en_o      (stream_en)
	);

endmodule

//--- src/cam_word_packer.sv
// Camera byte packer
// Collects four valid camera bytes into one buffer word, first byte in
// the top byte, and steps the word address across both buffer banks
`timescale 1ns/10ps

module cam_word_packer #(
	parameter int BANK_WORDS = 512
) (
	input  logic                     WBs_CLK_i,
	input  logic                     WBs_RST_i,
	input  capture_pkg::cam_byte_t   cam_dat_i,
	input  logic                     href_i,
	input  logic                     vsync_i,
	output capture_pkg::pixel_word_u word_o,
	output logic                     word_valid_o,
	output capture_pkg::bank_addr_t  wr_addr_o,
	output logic                     wr_bank_o
);

	localparam int CNT_W = $clog2(2 * BANK_WORDS); // Bank bit plus word address

	logic             byte_valid;
	logic [1:0]       byte_cnt;
	logic [CNT_W-1:0] word_cnt;

	assign byte_valid = href_i & vsync_i;   // Line and frame both active

	// --------------------------------------------------
	// Byte and word counters
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			byte_cnt     <= 2'd0;
			word_cnt     <= '0;
			word_valid_o <= 1'b0;
		end else begin
			word_valid_o <= byte_valid && (byte_cnt == 2'd3); // Fourth byte in
			if (byte_valid)
				byte_cnt <= byte_cnt + 2'd1;   // Wraps after four bytes
			if (word_valid_o) begin
				if (word_cnt == CNT_W'(2 * BANK_WORDS - 1))
					word_cnt <= '0;            // Back to bank 0
				else
					word_cnt <= word_cnt + 1'b1;
			end
		end
	end

	// Word register doubles as accumulator, stable during the pulse
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_valid)
			word_o.bytes[2'd3 - byte_cnt] <= cam_dat_i; // MSB first
	end

	assign wr_addr_o = capture_pkg::bank_addr_t'(word_cnt[CNT_W-2:0]);
	assign wr_bank_o = word_cnt[CNT_W-1];  // Upper count bit picks bank

	// Four bytes per word, so pulses never touch
	a_valid_gap : assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		word_valid_o |=> !word_valid_o);

endmodule

//--- src/capture_pkg.sv
// Camera capture definitions
// Byte and word types for the pixel path, frame buffer addressing
// and the layout of the host status and mode words
package capture_pkg;

	typedef logic [7:0] cam_byte_t;            // One camera byte

	// Buffer word, filled as bytes and sent as nibbles
	typedef union packed {
		cam_byte_t [3:0]  bytes;               // Index 3 is first captured byte
		logic [7:0][3:0]  nibbles;             // Index 7 goes out first
	} pixel_word_u;

	typedef logic [8:0]  bank_addr_t;          // Word address in one bank
	typedef logic [31:0] host_word_t;          // Host data bus word

	// --------------------------------------------------
	// Host status and mode fields
	// --------------------------------------------------
	localparam int STAT_VSYNC_BIT = 8;         // Live VSYNC level
	localparam int STAT_BANK_BIT  = 0;         // Bank the camera is filling

	localparam logic [1:0] MODE_STREAM = 2'b10; // Mode bits 1:0, stream to SRAM

endpackage

//--- src/frame_buffer.sv
// Ping-pong frame buffer
// Two word banks with a write port from the camera packer and an
// independent registered read port for the quad-SPI writer
`timescale 1ns/10ps

module frame_buffer #(
	parameter int BANK_WORDS = 512
) (
	input  logic                     WBs_CLK_i,
	input  logic                     wr_en_i,
	input  logic                     wr_bank_i,
	input  capture_pkg::bank_addr_t  wr_addr_i,
	input  capture_pkg::pixel_word_u wr_data_i,
	input  logic                     rd_en_i,
	input  logic                     rd_bank_i,
	input  capture_pkg::bank_addr_t  rd_addr_i,
	output capture_pkg::pixel_word_u rd_data_o
);

	// Bank 0 and bank 1 storage
	capture_pkg::pixel_word_u mem [0:1][0:BANK_WORDS-1];

	// --------------------------------------------------
	// Write port
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en_i)
			mem[wr_bank_i][wr_addr_i] <= wr_data_i; // One word per valid pulse
	end

	// --------------------------------------------------
	// Read port
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		if (rd_en_i)
			rd_data_o <= mem[rd_bank_i][rd_addr_i]; // Data one cycle after enable
	end

endmodule

//--- src/qspi_pkg.sv
// Quad-SPI serial SRAM protocol definitions
// Command codes, SRAM address type and the states of the burst writer
package qspi_pkg;

	typedef logic [7:0]  qspi_cmd_t;           // Command byte, sent MSB first
	typedef logic [23:0] qspi_addr_t;          // SRAM byte address

	// --------------------------------------------------
	// Command set
	// --------------------------------------------------
	localparam qspi_cmd_t CMD_QUAD_WRITE = 8'h38; // Quad write, serial command phase

	// --------------------------------------------------
	// Burst writer states
	// --------------------------------------------------
	typedef enum logic [2:0] {
		IDLE    = 3'd0,                        // Waiting for stream enable
		CMD     = 3'd1,                        // 8 command bits on io[0]
		ADDR    = 3'd2,                        // 6 address nibbles
		DATA    = 3'd3,                        // 8 nibbles per buffer word
		GAP     = 3'd4,                        // Chip select high between bursts
		HANDOFF = 3'd5                         // Waiting for the camera to swap banks
	} qspi_state_e;

	// Data nibbles per buffer word
	localparam int NIBBLES_PER_WORD = 8;

	// Address nibbles per burst header
	localparam int ADDR_NIBBLES = 6;

endpackage

//--- src/qspi_stream_writer.sv
// Quad-SPI burst writer
// Streams each completed frame buffer bank to the serial SRAM as
// fixed-size quad write bursts and swaps banks behind the camera
`timescale 1ns/10ps

module qspi_stream_writer #(
	parameter int BANK_WORDS      = 512,
	parameter int BURST_BYTES     = 512,
	parameter int QSPI_START_ADDR = 4
) (
	input  logic                     WBs_CLK_i,
	input  logic                     WBs_RST_i,
	input  logic                     stream_en_i,
	input  logic                     cam_bank_i,
	output logic                     rd_en_o,
	output logic                     rd_bank_o,
	output capture_pkg::bank_addr_t  rd_addr_o,
	input  capture_pkg::pixel_word_u rd_data_i,
	output logic [3:0]               qspi_io_o,
	output logic                     qspi_ncs_o
);

	localparam int BYTE_W = $clog2(BURST_BYTES);
	localparam logic [BYTE_W-1:0] LAST_BYTE = BYTE_W'(BURST_BYTES - 4); // Last word offset

	qspi_pkg::qspi_state_e    state;
	logic [2:0]               step_cnt;       // Bit, nibble or gap step
	logic [BYTE_W-1:0]        byte_cnt;       // Bytes sent in this burst
	qspi_pkg::qspi_addr_t     burst_addr;     // SRAM address of next burst
	qspi_pkg::qspi_cmd_t      cmd_sh;
	qspi_pkg::qspi_addr_t     addr_sh;
	capture_pkg::pixel_word_u data_sh;
	logic                     last_word;

	assign last_word = (byte_cnt == LAST_BYTE);

	// --------------------------------------------------
	// Burst sequencing and pin drive
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state      <= qspi_pkg::IDLE;
			step_cnt   <= 3'd0;
			byte_cnt   <= '0;
			burst_addr <= '0;
			rd_en_o    <= 1'b0;
			rd_bank_o  <= 1'b0;
			rd_addr_o  <= '0;
			qspi_io_o  <= 4'h0;
			qspi_ncs_o <= 1'b1;               // Deselected
		end else begin
			rd_en_o <= 1'b0;                  // Read strobe is one cycle
			if (rd_en_o) begin                // Step past the word just read
				if (rd_addr_o == capture_pkg::bank_addr_t'(BANK_WORDS - 1))
					rd_addr_o <= '0;
				else
					rd_addr_o <= rd_addr_o + 1'b1;
			end
			case (state)
				qspi_pkg::IDLE: begin
					// Bank 0 is full once the camera moves to bank 1
					if (stream_en_i && cam_bank_i) begin
						state      <= qspi_pkg::CMD;
						step_cnt   <= 3'd0;
						byte_cnt   <= '0;
						rd_bank_o  <= 1'b0;
						rd_addr_o  <= '0;
						burst_addr <= qspi_pkg::qspi_addr_t'(QSPI_START_ADDR);
					end
				end
				qspi_pkg::CMD: begin
					qspi_ncs_o <= 1'b0;           // Select with the first bit
					qspi_io_o  <= {3'b000, cmd_sh[7]};
					step_cnt   <= step_cnt + 3'd1; // Wraps to 0 for ADDR
					if (step_cnt == 3'd7)
						state <= qspi_pkg::ADDR;
				end
				qspi_pkg::ADDR: begin
					qspi_io_o <= addr_sh[23:20];
					if (step_cnt == 3'd3)
						rd_en_o <= 1'b1;          // Fetch first word of burst
					if (step_cnt == 3'(qspi_pkg::ADDR_NIBBLES - 1)) begin
						state    <= qspi_pkg::DATA;
						step_cnt <= 3'd0;
					end else begin
						step_cnt <= step_cnt + 3'd1;
					end
				end
				qspi_pkg::DATA: begin
					qspi_io_o <= data_sh.nibbles[7];
					step_cnt  <= step_cnt + 3'd1;
					if (step_cnt == 3'd5 && !last_word)
						rd_en_o <= 1'b1;          // Prefetch next word
					if (step_cnt == 3'(qspi_pkg::NIBBLES_PER_WORD - 1)) begin
						if (last_word) begin
							byte_cnt   <= '0;
							burst_addr <= burst_addr + qspi_pkg::qspi_addr_t'(BURST_BYTES);
							state      <= qspi_pkg::GAP;
						end else begin
							byte_cnt <= byte_cnt + BYTE_W'(4);
						end
					end
				end
				qspi_pkg::GAP: begin
					qspi_ncs_o <= 1'b1;           // Two cycles deselected
					qspi_io_o  <= 4'h0;
					step_cnt   <= step_cnt + 3'd1;
					if (step_cnt == 3'd1) begin
						step_cnt <= 3'd0;
						// Read address wrapped, so the whole bank is out
						state <= (rd_addr_o == '0) ? qspi_pkg::HANDOFF : qspi_pkg::CMD;
					end
				end
				qspi_pkg::HANDOFF: begin
					// Camera back in our bank means the other one is full
					if (cam_bank_i == rd_bank_o) begin
						rd_bank_o <= ~rd_bank_o;
						state     <= qspi_pkg::CMD;
					end
				end
				default: state <= qspi_pkg::IDLE;
			endcase
		end
	end

	// --------------------------------------------------
	// Shift registers for command, address and data
	// --------------------------------------------------
	always_ff @(posedge WBs_CLK_i) begin
		case (state)
			qspi_pkg::CMD: begin
				cmd_sh <= {cmd_sh[6:0], 1'b0};
				if (step_cnt == 3'd7)
					addr_sh <= burst_addr;        // Ready for the address phase
			end
			qspi_pkg::ADDR: begin
				addr_sh <= {addr_sh[19:0], 4'h0};
				if (step_cnt == 3'(qspi_pkg::ADDR_NIBBLES - 1))
					data_sh <= rd_data_i;         // First word of the burst
			end
			qspi_pkg::DATA: begin
				if (step_cnt == 3'(qspi_pkg::NIBBLES_PER_WORD - 1))
					data_sh <= rd_data_i;         // Prefetched word
				else
					data_sh.nibbles <= {data_sh.nibbles[6:0], 4'h0};
			end
			default: cmd_sh <= qspi_pkg::CMD_QUAD_WRITE; // Reload between bursts
		endcase
	end

	// Chip select low only right after a burst phase drove the pins
	a_ncs_idle : assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		!qspi_ncs_o |->
			($past(state) inside {qspi_pkg::CMD, qspi_pkg::ADDR, qspi_pkg::DATA}));

endmodule

//--- src/wb_ctrl_regs.sv
// Host control registers
// Single-cycle acknowledge for the status cycle, the mode register that
// enables streaming, and the live capture status word
`timescale 1ns/10ps

module wb_ctrl_regs (
	input  logic                    WBs_CLK_i,
	input  logic                    WBs_RST_i,
	input  logic                    WBs_STATUS_CYC_i,
	input  logic                    WBs_STB_i,
	input  logic                    WBs_WE_i,
	input  capture_pkg::host_word_t WBs_DAT_i,
	input  logic                    vsync_i,
	input  logic                    cam_bank_i,
	output logic                    WBs_ACK_o,
	output capture_pkg::host_word_t WBs_STATUS_o,
	output logic                    stream_en_o
);

	logic       access;
	logic [1:0] mode_q;                       // Mode bits 1:0

	// New access only while no acknowledge is pending
	assign access = WBs_STATUS_CYC_i & WBs_STB_i & ~WBs_ACK_o;

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			WBs_ACK_o <= 1'b0;
			mode_q    <= 2'b00;               // Streaming off
		end else begin
			WBs_ACK_o <= access;
			if (access && WBs_WE_i)
				mode_q <= WBs_DAT_i[1:0];
		end
	end

	assign stream_en_o = (mode_q == capture_pkg::MODE_STREAM);

	// Status word, live camera state
	always_comb begin
		WBs_STATUS_o = '0;
		WBs_STATUS_o[capture_pkg::STAT_VSYNC_BIT] = vsync_i;
		WBs_STATUS_o[capture_pkg::STAT_BANK_BIT]  = cam_bank_i;
	end

	// Host sees one acknowledge per strobed access
	a_ack_single : assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		WBs_ACK_o |=> !WBs_ACK_o);

endmodule

//--- testbench/tb_model.svh
// Testbench reference model
// Rebuilds the expected buffer words from the driven camera bytes and
// gives the expected SRAM burst address, camera bank and status word
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

capture_pkg::pixel_word_u exp_words[$];        // Captured words, oldest first
logic [31:0]              byte_acc    = '0;    // Word being built
int                       byte_num    = 0;     // Bytes in byte_acc
int                       words_total = 0;     // Words captured since reset

// One valid camera byte, first byte ends up on top
function automatic void add_cam_byte(capture_pkg::cam_byte_t b);
	capture_pkg::pixel_word_u w;
	byte_acc = {byte_acc[23:0], b};
	byte_num++;
	if (byte_num == 4) begin
		w = byte_acc;
		exp_words.push_back(w);
		byte_num = 0;
		words_total++;
	end
endfunction

// SRAM address of burst number idx
function automatic qspi_pkg::qspi_addr_t burst_addr_for(int idx);
	return qspi_pkg::qspi_addr_t'(QSPI_START_ADDR + BURST_BYTES * idx);
endfunction

// Bank the camera fills after n words
function automatic logic bank_for_words(int n);
	return ((n / BANK_WORDS) % 2) != 0;
endfunction

// VSYNC in bit 8, bank in bit 0, rest zero
function automatic capture_pkg::host_word_t status_for(logic vs, logic bank);
	capture_pkg::host_word_t s;
	s    = '0;
	s[8] = vs;
	s[0] = bank;
	return s;
endfunction

`endif

//--- testbench/tb_cam_qspi_top.sv
// Testbench for the camera to quad-SPI capture top level
// Random camera bytes, host register accesses and a quad-SPI monitor
// that rebuilds every burst and compares it with the reference model
`timescale 1ns/10ps

module tb_cam_qspi_top;

	localparam int BANK_WORDS      = 512;
	localparam int BURST_BYTES     = 512;
	localparam int QSPI_START_ADDR = 4;
	localparam int BURST_CYCLES    = 8 + 6 + 2 * BURST_BYTES; // Cmd bits, addr and data nibbles
	localparam int BURSTS_WANTED   = 16;                       // Four banks, three handoffs
	localparam qspi_pkg::qspi_cmd_t EXP_CMD = 8'h38;

	logic                    WBs_CLK_i = 1'b0;
	logic                    WBs_RST_i;
	logic                    WBs_STATUS_CYC_i;
	logic                    WBs_STB_i;
	logic                    WBs_WE_i;
	capture_pkg::host_word_t WBs_DAT_i;
	logic                    WBs_ACK_o;
	capture_pkg::host_word_t WBs_STATUS_o;
	capture_pkg::cam_byte_t  cam_dat_i;
	logic                    href_i;
	logic                    vsync_i;
	logic [3:0]              qspi_io_o;
	logic                    qspi_ncs_o;

	logic                 cam_hold = 1'b0;     // Camera pauses at slot end
	logic                 cam_idle = 1'b0;
	logic                 cam_stop = 1'b0;
	logic                 mode_set = 1'b0;     // Streaming mode written
	int                   value_errs   = 0;
	int                   proto_errs   = 0;
	int                   timeout_errs = 0;
	int                   bursts_seen  = 0;    // Completed bursts
	int                   low_cnt      = 0;    // Cycles into current burst
	int                   gap_cnt      = 0;    // Cycles with chip select high
	int                   words_checked = 0;
	qspi_pkg::qspi_cmd_t  cmd_acc;
	qspi_pkg::qspi_addr_t addr_acc;
	logic [31:0]          nib_acc;

	`include "tb_model.svh"

	cam_qspi_top #(
		.BANK_WORDS      (BANK_WORDS),
		.BURST_BYTES     (BURST_BYTES),
		.QSPI_START_ADDR (QSPI_START_ADDR)
	) i_cam_qspi_top (
		.WBs_CLK_i        (WBs_CLK_i),
		.WBs_RST_i        (WBs_RST_i),
		.WBs_STATUS_CYC_i (WBs_STATUS_CYC_i),
		.WBs_STB_i        (WBs_STB_i),
		.WBs_WE_i         (WBs_WE_i),
		.WBs_DAT_i        (WBs_DAT_i),
		.WBs_ACK_o        (WBs_ACK_o),
		.WBs_STATUS_o     (WBs_STATUS_o),
		.cam_dat_i        (cam_dat_i),
		.href_i           (href_i),
		.vsync_i          (vsync_i),
		.qspi_io_o        (qspi_io_o),
		.qspi_ncs_o       (qspi_ncs_o)
	);

	always #2 WBs_CLK_i = ~WBs_CLK_i;          // 4 ns period

	// --------------------------------------------------
	// Compare tasks
	// --------------------------------------------------
	task automatic check_word(capture_pkg::pixel_word_u got, capture_pkg::pixel_word_u exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error at %0t: data word %0d got %h expected %h",
				$time, words_checked, got, exp);
		end
	endtask

	task automatic check_cmd(qspi_pkg::qspi_cmd_t got, qspi_pkg::qspi_cmd_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error at %0t: burst %0d command got %h expected %h",
				$time, bursts_seen, got, exp);
		end
	endtask

	task automatic check_addr(qspi_pkg::qspi_addr_t got, qspi_pkg::qspi_addr_t exp);
		if (got !== exp) begin
			value_errs++;
			$display("** Error at %0t: burst %0d address got %h expected %h",
				$time, bursts_seen, got, exp);
		end
	endtask

	task automatic check_status(capture_pkg::host_word_t got, capture_pkg::host_word_t exp,
	                            string what);
		if (got !== exp) begin
			value_errs++;
			$display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic report_fault(string msg);
		proto_errs++;
		$display("Protocol error at %0t: %s", $time, msg);
	endtask

	// --------------------------------------------------
	// Camera byte source
	// --------------------------------------------------
	task automatic run_camera();
		int gap;
		while (!cam_stop) begin
			if (cam_hold) begin
				cam_idle = 1'b1;               // Host owns vsync now
				@(posedge WBs_CLK_i);
				#1;
			end else begin
				cam_idle  = 1'b0;
				cam_dat_i = capture_pkg::cam_byte_t'($urandom);
				href_i    = 1'b1;
				vsync_i   = ($urandom_range(15) != 0); // Occasional frame gap
				if (vsync_i)
					add_cam_byte(cam_dat_i);
				@(posedge WBs_CLK_i);
				#1;
				href_i  = 1'b0;
				vsync_i = 1'b1;
				gap     = $urandom_range(6, 3);   // Keeps words 16+ cycles apart
				repeat (gap) @(posedge WBs_CLK_i);
				#1;
			end
		end
	endtask

	// Host access, acknowledge must follow exactly one cycle later
	task automatic host_access(input logic we, input capture_pkg::host_word_t dat,
	                           output capture_pkg::host_word_t status);
		WBs_STATUS_CYC_i = 1'b1;
		WBs_STB_i        = 1'b1;
		WBs_WE_i         = we;
		WBs_DAT_i        = dat;
		@(negedge WBs_CLK_i);
		if (WBs_ACK_o !== 1'b0)
			report_fault("acknowledge high in the strobe cycle");
		@(posedge WBs_CLK_i);
		#1;
		@(negedge WBs_CLK_i);
		status = WBs_STATUS_o;
		if (WBs_ACK_o !== 1'b1)
			report_fault("no acknowledge in the cycle after the access");
		@(posedge WBs_CLK_i);
		#1;
		WBs_STATUS_CYC_i = 1'b0;          // Master drops strobe after seeing ACK
		WBs_STB_i        = 1'b0;
		WBs_WE_i         = 1'b0;
		@(negedge WBs_CLK_i);
		if (WBs_ACK_o !== 1'b0)
			report_fault("acknowledge held for a second cycle");
		@(posedge WBs_CLK_i);
		#1;
	endtask

	// --------------------------------------------------
	// Bounded waits
	// --------------------------------------------------
	task automatic wait_for_words(int n, int limit, output logic ok);
		int cnt;
		cnt = 0;
		while (words_total < n && cnt < limit) begin
			@(posedge WBs_CLK_i);
			#1;
			cnt++;
		end
		ok = (words_total >= n);
		if (!ok) begin
			timeout_errs++;
			$display("Timeout: camera did not reach %0d words", n);
		end
	endtask

	task automatic wait_cam_idle(int limit, output logic ok);
		int cnt;
		cnt = 0;
		while (!cam_idle && cnt < limit) begin
			@(posedge WBs_CLK_i);
			#1;
			cnt++;
		end
		ok = cam_idle;
		if (!ok) begin
			timeout_errs++;
			$display("Timeout: camera source did not pause");
		end
	endtask

	task automatic wait_for_bursts(int n, int limit, output logic ok);
		int cnt;
		cnt = 0;
		while (bursts_seen < n && cnt < limit) begin
			@(posedge WBs_CLK_i);
			#1;
			cnt++;
		end
		ok = (bursts_seen >= n);
		if (!ok) begin
			timeout_errs++;
			$display("Timeout: only %0d of %0d bursts finished", bursts_seen, n);
		end
	endtask

	// --------------------------------------------------
	// Quad-SPI monitor
	// --------------------------------------------------
	always @(negedge WBs_CLK_i) begin : qspi_monitor
		capture_pkg::pixel_word_u got_word;
		if (!WBs_RST_i && !qspi_ncs_o) begin
			if (low_cnt == 0) begin
				if (!mode_set)
					report_fault("chip select dropped before streaming was enabled");
				if (bursts_seen > 0 && gap_cnt < 2)
					report_fault("chip select high for less than 2 cycles between bursts");
			end
			if (low_cnt < 8) begin                       // Command, MSB first on io[0]
				cmd_acc = {cmd_acc[6:0], qspi_io_o[0]};
				if (qspi_io_o[3:1] != 3'b000)
					report_fault("upper io bits active during the command");
				if (low_cnt == 7)
					check_cmd(cmd_acc, EXP_CMD);
			end else if (low_cnt < 14) begin             // Six address nibbles
				addr_acc = {addr_acc[19:0], qspi_io_o};
				if (low_cnt == 13)
					check_addr(addr_acc, burst_addr_for(bursts_seen));
			end else begin
				nib_acc = {nib_acc[27:0], qspi_io_o};   // Highest nibble first
				if ((low_cnt - 14) % 8 == 7) begin
					got_word = nib_acc;
					if (exp_words.size() == 0)
						report_fault("data word sent before it was captured");
					else
						check_word(got_word, exp_words.pop_front());
					words_checked++;
				end
			end
			low_cnt++;
			gap_cnt = 0;
		end else if (!WBs_RST_i) begin
			if (low_cnt != 0) begin                      // Burst just ended
				if (low_cnt != BURST_CYCLES)
					report_fault($sformatf("burst lasted %0d cycles instead of %0d",
						low_cnt, BURST_CYCLES));
				bursts_seen++;
				low_cnt = 0;
			end
			gap_cnt++;
		end
	end

	task automatic finish_run();
		$display("Checked %0d words in %0d bursts, errors: value %0d, protocol %0d, timeout %0d",
			words_checked, bursts_seen, value_errs, proto_errs, timeout_errs);
		if (value_errs + proto_errs + timeout_errs == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	endtask

	// --------------------------------------------------
	// Main sequence
	// --------------------------------------------------
	initial begin
		capture_pkg::host_word_t status;
		capture_pkg::host_word_t mode_word;
		logic                    ok;
		WBs_RST_i        = 1'b1;
		WBs_STATUS_CYC_i = 1'b0;
		WBs_STB_i        = 1'b0;
		WBs_WE_i         = 1'b0;
		WBs_DAT_i        = '0;
		cam_dat_i        = '0;
		href_i           = 1'b0;
		vsync_i          = 1'b1;
		void'($urandom(32'hc3));
		repeat (8) @(posedge WBs_CLK_i);
		#1;
		WBs_RST_i = 1'b0;
		@(negedge WBs_CLK_i);
		if (qspi_ncs_o !== 1'b1 || WBs_ACK_o !== 1'b0 || qspi_io_o !== 4'h0)
			report_fault("outputs not at their reset values");
		@(posedge WBs_CLK_i);
		#1;
		fork
			run_camera();
		join_none

		// Camera well into bank 1 with streaming still off
		wait_for_words(BANK_WORDS + 8, 30000, ok);
		if (ok) begin
			cam_hold = 1'b1;
			wait_cam_idle(20, ok);
		end
		if (ok) begin
			repeat (4) @(posedge WBs_CLK_i); // Bank bit settles after last word
			#1;
			host_access(1'b0, $urandom, status);
			check_status(status, status_for(1'b1, bank_for_words(words_total)),
				"status with vsync high");
			mode_word      = $urandom;
			mode_word[1:0] = 2'b10;           // Stream mode
			mode_set       = 1'b1;
			host_access(1'b1, mode_word, status);
			vsync_i = 1'b0;
			host_access(1'b0, $urandom, status);
			check_status(status, status_for(1'b0, bank_for_words(words_total)),
				"status with vsync low");
			vsync_i  = 1'b1;
			cam_hold = 1'b0;
			wait_for_bursts(BURSTS_WANTED, 150000, ok);
		end
		cam_stop = 1'b1;
		finish_run();
	end

endmodule
